//--- Makefile
TOP = tb_forth_serial

all: run

run:
	verilator --binary --timing --assert -f forth_serial.f --top-module $(TOP) -o $(TOP)
	out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "Test completed successfully"

lint:
	verilator --lint-only --timing -Wall -f forth_serial.f --top-module forth_serial

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

//--- forth_serial.f
+incdir+tests
src/forth_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/data_stack.sv
src/forth_interp.sv
src/forth_serial.sv
tests/tb_forth_serial.sv

//--- src/data_stack.sv
`timescale 1ns/1ps
//////////////////////////////
// Forth data stack
// 16 circular cells with the ALU that
// applies one stack operation per cycle
//////////////////////////////
module data_stack import forth_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  stack_op_e stack_op,
	input  cell_t     push_data,
	output cell_t     top
);

	cell_t cells [STACK_DEPTH];
	sp_t   sp;
	sp_t   sp_up;
	sp_t   sp_dn;
	cell_t second;

	// Write port and next pointer
	logic  wr_en;
	sp_t   wr_addr;
	cell_t wr_data;
	sp_t   sp_next;

	// Pointer wraps, no overflow or underflow check
	assign sp_up  = sp + 1'b1;
	assign sp_dn  = sp - 1'b1;
	assign top    = cells[sp];
	assign second = cells[sp_dn];

	//////////////////////////////
	// ALU
	//////////////////////////////
	always_comb begin
		wr_en   = 1'b1;
		wr_addr = sp_dn;
		wr_data = top;
		sp_next = sp_dn;
		case (stack_op)
			OP_PUSH: begin
				wr_addr = sp_up;
				wr_data = push_data;
				sp_next = sp_up;
			end
			// Binary ops land one cell down
			OP_ADD: wr_data = second + top;
			OP_SUB: wr_data = second - top;
			OP_AND: wr_data = second & top;
			OP_OR:  wr_data = second | top;
			OP_EQ:  wr_data = (second == top) ? '1 : '0;
			OP_DUP: begin
				wr_addr = sp_up;
				sp_next = sp_up;
			end
			OP_OVER: begin
				wr_addr = sp_up;
				wr_data = second;
				sp_next = sp_up;
			end
			// Only the pointer moves
			OP_DROP: wr_en = 1'b0;
			// Unary ops rewrite the top in place
			OP_NEGATE: begin
				wr_addr = sp;
				wr_data = -top;
				sp_next = sp;
			end
			OP_NOT: begin
				wr_addr = sp;
				wr_data = ~top;
				sp_next = sp;
			end
			OP_ZERO_EQ: begin
				wr_addr = sp;
				wr_data = (top == '0) ? '1 : '0;
				sp_next = sp;
			end
			default: begin
				wr_en   = 1'b0;
				sp_next = sp;
			end
		endcase
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			sp <= '0;
			for (int i = 0; i < STACK_DEPTH; i++) begin
				cells[i] <= '0;
			end
		end else begin
			sp <= sp_next;
			if (wr_en) begin
				cells[wr_addr] <= wr_data;
			end
		end
	end

	// Interpreter always drives a defined op
	a_op_known: assert property (@(posedge clk) disable iff (!reset) !$isunknown(stack_op))
		else $error("stack_op unknown");

endmodule

//--- src/forth_interp.sv
`timescale 1ns/1ps
//////////////////////////////
// Forth word interpreter
// Decodes each received character as a word
// and drives stack, emit, LED and error actions
//////////////////////////////
module forth_interp import forth_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  byte_t     rx_data,
	input  logic      rx_valid,
	output logic      rx_ready,
	output stack_op_e stack_op,
	output cell_t     push_data,
	input  cell_t     top,
	output byte_t     tx_data,
	output logic      tx_valid,
	input  logic      tx_ready,
	output logic      led_r,
	output logic      led_g,
	output logic      led_b
);

	interp_state_e state;
	byte_t         word_q;
	led_t          led_q;
	stack_op_e     dec_op;
	logic          is_emit;
	logic          is_led;
	logic          is_error;

	assign rx_ready  = (state == IDLE);
	// One stack op, and only in DECODE
	assign stack_op  = (state == DECODE) ? dec_op : OP_NONE;
	// Single-digit number
	assign push_data = cell_t'(word_q - CHAR_ZERO);

	// Active-low RGB
	assign led_g = led_q[0];
	assign led_b = led_q[1];
	assign led_r = led_q[2];

	//////////////////////////////
	// Word decode
	//////////////////////////////
	always_comb begin
		dec_op   = OP_NONE;
		is_emit  = 1'b0;
		is_led   = 1'b0;
		is_error = 1'b0;
		case (word_q) inside
			[CHAR_ZERO:CHAR_NINE]: dec_op = OP_PUSH;
			CHAR_ADD:     dec_op = OP_ADD;
			CHAR_SUB:     dec_op = OP_SUB;
			CHAR_AND:     dec_op = OP_AND;
			CHAR_OR:      dec_op = OP_OR;
			CHAR_EQ:      dec_op = OP_EQ;
			CHAR_DUP:     dec_op = OP_DUP;
			CHAR_OVER:    dec_op = OP_OVER;
			CHAR_DROP:    dec_op = OP_DROP;
			CHAR_NEGATE:  dec_op = OP_NEGATE;
			CHAR_NOT:     dec_op = OP_NOT;
			CHAR_ZERO_EQ: dec_op = OP_ZERO_EQ;
			// Emit and io_led both consume the top cell
			CHAR_EMIT: begin
				dec_op  = OP_DROP;
				is_emit = 1'b1;
			end
			CHAR_LED: begin
				dec_op = OP_DROP;
				is_led = 1'b1;
			end
			// Blanks do nothing
			CHAR_SPACE, [CHAR_LF:CHAR_CR]: dec_op = OP_NONE;
			default: is_error = 1'b1;
		endcase
	end

	// Control FSM
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state    <= IDLE;
			tx_valid <= 1'b0;
			led_q    <= '1;
		end else begin
			case (state)
				IDLE: begin
					if (rx_valid) begin
						state <= DECODE;
					end
				end
				DECODE: begin
					if (is_led) begin
						led_q <= ~top[2:0];
					end
					if (is_emit || is_error) begin
						tx_valid <= 1'b1;
						state    <= EMIT_WAIT;
					end else begin
						state <= IDLE;
					end
				end
				EMIT_WAIT: begin
					// Leaves on the transfer edge
					if (tx_ready) begin
						tx_valid <= 1'b0;
						state    <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Word and outgoing byte
	always_ff @(posedge clk) begin
		if (state == IDLE && rx_valid) begin
			word_q <= rx_data;
		end
		// Top is still the pre-drop value here
		if (state == DECODE) begin
			tx_data <= is_emit ? top[7:0] : CHAR_ERROR;
		end
	end

	a_tx_hold: assert property (@(posedge clk) disable iff (!reset)
		tx_valid && !tx_ready |=> tx_valid && $stable(tx_data))
		else $error("tx_valid dropped or tx_data changed before tx_ready");

endmodule

//--- src/forth_pkg.sv
//////////////////////////////
// Forth serial shared definitions
// Cell and byte widths, UART bit timing,
// the one-character word codes and the
// stack operation and FSM encodings
//////////////////////////////
package forth_pkg;

	// Data widths
	typedef logic [31:0] cell_t;
	typedef logic [7:0]  byte_t;
	// Bit 0 green, bit 1 blue, bit 2 red
	typedef logic [2:0]  led_t;

	// Circular data stack
	localparam int STACK_DEPTH = 16;
	typedef logic [$clog2(STACK_DEPTH)-1:0] sp_t;

	// Clocks per UART bit, any value above 4
	localparam int CLKS_PER_BIT = 16;
	typedef logic [$clog2(CLKS_PER_BIT)-1:0] bit_cnt_t;

	//////////////////////////////
	// Word characters
	//////////////////////////////
	localparam byte_t CHAR_ZERO    = "0";
	localparam byte_t CHAR_NINE    = "9";
	localparam byte_t CHAR_ADD     = "+";
	localparam byte_t CHAR_SUB     = "-";
	localparam byte_t CHAR_AND     = "&";
	localparam byte_t CHAR_OR      = "|";
	localparam byte_t CHAR_EQ      = "=";
	localparam byte_t CHAR_DUP     = "d";
	localparam byte_t CHAR_OVER    = "o";
	localparam byte_t CHAR_DROP    = "x";
	localparam byte_t CHAR_NEGATE  = "n";
	localparam byte_t CHAR_NOT     = "~";
	localparam byte_t CHAR_ZERO_EQ = "z";
	localparam byte_t CHAR_EMIT    = ".";
	localparam byte_t CHAR_LED     = "l";
	// Blanks: space and LF through CR
	localparam byte_t CHAR_SPACE   = " ";
	localparam byte_t CHAR_LF      = 8'd10;
	localparam byte_t CHAR_CR      = 8'd13;
	// Reply to an unknown word
	localparam byte_t CHAR_ERROR   = "?";

	typedef enum logic [3:0] {
		OP_NONE, OP_PUSH, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_EQ,
		OP_DUP, OP_OVER, OP_DROP, OP_NEGATE, OP_NOT, OP_ZERO_EQ
	} stack_op_e;

	// Interpreter FSM
	typedef enum logic [1:0] {IDLE, DECODE, EMIT_WAIT} interp_state_e;

endpackage

//--- src/forth_serial.sv
`timescale 1ns/1ps
//////////////////////////////
// Serial Forth processor top
// UART in, interpreter and stack, UART out
//////////////////////////////
module forth_serial import forth_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic rx,
	output logic tx,
	output logic led_r,
	output logic led_g,
	output logic led_b
);

	// Receive stream
	byte_t     rx_data;
	logic      rx_valid;
	logic      rx_ready;
	// Transmit stream
	byte_t     tx_data;
	logic      tx_valid;
	logic      tx_ready;
	// Stack port
	stack_op_e stack_op;
	cell_t     push_data;
	cell_t     top;

	uart_rx u_uart_rx (
		.clk      (clk),
		.reset    (reset),
		.rx       (rx),
		.rx_data  (rx_data),
		.rx_valid (rx_valid),
		.rx_ready (rx_ready)
	);

	forth_interp u_forth_interp (
		.clk       (clk),
		.reset     (reset),
		.rx_data   (rx_data),
		.rx_valid  (rx_valid),
		.rx_ready  (rx_ready),
		.stack_op  (stack_op),
		.push_data (push_data),
		.top       (top),
		.tx_data   (tx_data),
		.tx_valid  (tx_valid),
		.tx_ready  (tx_ready),
		.led_r     (led_r),
		.led_g     (led_g),
		.led_b     (led_b)
	);

	data_stack u_data_stack (
		.clk       (clk),
		.reset     (reset),
		.stack_op  (stack_op),
		.push_data (push_data),
		.top       (top)
	);

	uart_tx u_uart_tx (
		.clk      (clk),
		.reset    (reset),
		.tx_data  (tx_data),
		.tx_valid (tx_valid),
		.tx_ready (tx_ready),
		.tx       (tx)
	);

endmodule

//--- src/uart_rx.sv
`timescale 1ns/1ps
//////////////////////////////
// UART receiver
// Samples 8N1 frames at the bit centres
// and holds each byte on a valid/ready stream
//////////////////////////////
module uart_rx import forth_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  rx,
	output byte_t rx_data,
	output logic  rx_valid,
	input  logic  rx_ready
);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

	rx_state_e  state;
	bit_cnt_t   clk_cnt;
	logic [2:0] bit_idx;
	logic       rx_meta;
	logic       rx_sync;
	logic       bit_end;

	// Two-flop synchronizer, line idles high
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	// Centre of a data or stop bit
	assign bit_end = (clk_cnt == bit_cnt_t'(CLKS_PER_BIT - 1));

	//////////////////////////////
	// Frame FSM
	//////////////////////////////
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state    <= RX_IDLE;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			// Byte taken by the interpreter
			if (rx_valid && rx_ready) begin
				rx_valid <= 1'b0;
			end
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					// Held byte blocks a new frame
					if (!rx_sync && !rx_valid) begin
						state <= RX_START;
					end
				end
				RX_START: begin
					if (clk_cnt == bit_cnt_t'(CLKS_PER_BIT / 2 - 1)) begin
						clk_cnt <= '0;
						// Glitch, not a start bit
						state   <= rx_sync ? RX_IDLE : RX_DATA;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (bit_end) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= RX_STOP;
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				RX_STOP: begin
					if (bit_end) begin
						clk_cnt <= '0;
						state   <= RX_IDLE;
						// Low stop bit means a framing error, byte dropped
						if (rx_sync) begin
							rx_valid <= 1'b1;
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// LSB first into the top of the shift register
	always_ff @(posedge clk) begin
		if (state == RX_DATA && bit_end) begin
			rx_data <= {rx_sync, rx_data[7:1]};
		end
	end

	// Offered byte stays until the interpreter takes it
	a_rx_hold: assert property (@(posedge clk) disable iff (!reset)
		rx_valid && !rx_ready |=> rx_valid && $stable(rx_data))
		else $error("rx_valid dropped or rx_data changed without a transfer");

endmodule

//--- src/uart_tx.sv
`timescale 1ns/1ps
//////////////////////////////
// UART transmitter
// Takes a byte on a valid/ready stream
// and shifts it out as an 8N1 frame
//////////////////////////////
module uart_tx import forth_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  byte_t tx_data,
	input  logic  tx_valid,
	output logic  tx_ready,
	output logic  tx
);

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

	tx_state_e  state;
	bit_cnt_t   clk_cnt;
	logic [2:0] bit_idx;
	byte_t      shift;
	logic       bit_end;

	// Ready only between frames
	assign tx_ready = (state == TX_IDLE);
	assign bit_end  = (clk_cnt == bit_cnt_t'(CLKS_PER_BIT - 1));

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state   <= TX_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			tx      <= 1'b1;
		end else begin
			if (state != TX_IDLE) begin
				clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
			end
			case (state)
				TX_IDLE: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					if (tx_valid) begin
						// Start bit from the next cycle
						tx    <= 1'b0;
						state <= TX_START;
					end
				end
				TX_START: begin
					if (bit_end) begin
						tx    <= shift[0];
						state <= TX_DATA;
					end
				end
				TX_DATA: begin
					if (bit_end) begin
						bit_idx <= bit_idx + 1'b1;
						// Stop bit after the eighth data bit
						tx      <= (bit_idx == 3'd7) ? 1'b1 : shift[0];
						if (bit_idx == 3'd7) begin
							state <= TX_STOP;
						end
					end
				end
				TX_STOP: begin
					if (bit_end) begin
						state <= TX_IDLE;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// Shifter, next bit always at shift[0]
	always_ff @(posedge clk) begin
		if (tx_ready && tx_valid) begin
			shift <= tx_data;
		end else if (bit_end && (state == TX_START || state == TX_DATA)) begin
			shift <= shift >> 1;
		end
	end

	// Line idles high between frames
	a_tx_idle: assert property (@(posedge clk) disable iff (!reset) tx_ready |-> tx)
		else $error("tx low while transmitter idle");

endmodule

//--- tests/tb_uart_tasks.svh
//////////////////////////////
// Testbench serial helpers
// UART byte driver, tx frame monitor,
// xorshift generator and the reference
// model of the circular data stack
//////////////////////////////
`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH

logic [31:0] rng_state = SEED;
cell_t       model_cells [16];
logic [3:0]  model_sp;
// Bit 0 green, bit 1 blue, bit 2 red, active low
logic [2:0]  model_led;
byte_t       rx_frames [$];
byte_t       expect_q [$];

function automatic logic [31:0] next_random();
	rng_state = rng_state ^ (rng_state << 13);
	rng_state = rng_state ^ (rng_state >> 17);
	rng_state = rng_state ^ (rng_state << 5);
	return rng_state;
endfunction

//////////////////////////////
// UART line
//////////////////////////////

// 8N1 frame, LSB first, then 3 idle bit times
task automatic send_byte(input byte_t b);
	rx = 1'b0;
	repeat (CLKS_PER_BIT) @(negedge clk);
	for (int i = 0; i < 8; i++) begin
		rx = b[i];
		repeat (CLKS_PER_BIT) @(negedge clk);
	end
	rx = 1'b1;
	repeat (4 * CLKS_PER_BIT) @(negedge clk);
endtask

// Samples tx at bit centres, one queue entry per frame
task automatic watch_tx();
	byte_t b;
	forever begin
		@(negedge clk);
		if (reset && !tx) begin
			repeat (CLKS_PER_BIT / 2) @(negedge clk);
			for (int i = 0; i < 8; i++) begin
				repeat (CLKS_PER_BIT) @(negedge clk);
				b[i] = tx;
			end
			repeat (CLKS_PER_BIT) @(negedge clk);
			if (!tx) begin
				$display("Framing error at %0t, stop bit on tx is low", $time);
				errors++;
			end
			rx_frames.push_back(b);
		end
	end
endtask

//////////////////////////////
// Stack model
//////////////////////////////

// Result of a two-cell word, one cell down
function automatic void set_below(input cell_t r);
	model_sp = model_sp - 1'b1;
	model_cells[model_sp] = r;
endfunction

function automatic void push_cell(input cell_t v);
	model_sp = model_sp + 1'b1;
	model_cells[model_sp] = v;
endfunction

function automatic void model_word(input byte_t w);
	cell_t t;
	cell_t s;
	t = model_cells[model_sp];
	s = model_cells[model_sp - 1'b1];
	case (w) inside
		["0":"9"]: push_cell(cell_t'(w - "0"));
		"+": set_below(s + t);
		"-": set_below(s - t);
		"&": set_below(s & t);
		"|": set_below(s | t);
		"=": set_below({32{s == t}});
		"d": push_cell(t);
		"o": push_cell(s);
		"x": model_sp = model_sp - 1'b1;
		"n": model_cells[model_sp] = -t;
		"~": model_cells[model_sp] = ~t;
		"z": model_cells[model_sp] = {32{t == 32'd0}};
		// emit and io_led consume the top
		".": begin
			expect_q.push_back(t[7:0]);
			model_sp = model_sp - 1'b1;
		end
		"l": begin
			model_led = ~t[2:0];
			model_sp = model_sp - 1'b1;
		end
		" ", [8'd10:8'd13]: model_led = model_led;
		default: expect_q.push_back("?");
	endcase
endfunction

function automatic logic word_is_known(input byte_t b);
	string known;
	known = "0123456789+-&|=doxn~z.l ";
	if (b inside {[8'd10:8'd13]}) begin
		return 1'b1;
	end
	for (int i = 0; i < known.len(); i++) begin
		if (known[i] == b) begin
			return 1'b1;
		end
	end
	return 1'b0;
endfunction

`endif

//--- tests/tb_forth_serial.sv
`timescale 1ns/1ps
//////////////////////////////
// Serial Forth processor testbench
// Random one-character programs over the UART,
// checked against a reference stack model
//////////////////////////////
module tb_forth_serial import forth_pkg::*; ();

	localparam logic [31:0] SEED = 32'd66040;
	localparam int NUM_PROGRAMS  = 24;
	// Longest wait for the expected tx frames, in clocks
	localparam int FRAME_TIMEOUT = 40 * CLKS_PER_BIT;

	logic clk = 1'b0;
	logic reset;
	logic rx;
	logic tx;
	logic led_r;
	logic led_g;
	logic led_b;
	int   errors = 0;
	int   err_mark = 0;
	int   tests_run = 0;
	int   tests_failed = 0;

	`include "tb_uart_tasks.svh"

	forth_serial u_forth_serial (
		.clk   (clk),
		.reset (reset),
		.rx    (rx),
		.tx    (tx),
		.led_r (led_r),
		.led_g (led_g),
		.led_b (led_b)
	);

	// 40 ns clock
	always #20 clk = ~clk;

	initial watch_tx();

	function automatic byte_t rand_digit();
		return "0" + byte_t'(next_random() % 10);
	endfunction

	task automatic send_word(input byte_t w);
		model_word(w);
		send_byte(w);
	endtask

	// Waits for the predicted frames, then compares in order
	task automatic check_frames();
		int waited;
		int n;
		waited = 0;
		while (rx_frames.size() < expect_q.size() && waited < FRAME_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (rx_frames.size() < expect_q.size()) begin
			$display("Timeout at %0t waiting for %0d tx frames, %0d arrived",
				$time, expect_q.size(), rx_frames.size());
			errors++;
		end
		// Room for a stray extra frame
		repeat (12 * CLKS_PER_BIT) @(negedge clk);
		if (rx_frames.size() != expect_q.size()) begin
			$display("FAIL t=%0t frame_count expected %0d got %0d",
				$time, expect_q.size(), rx_frames.size());
			errors++;
		end
		n = (rx_frames.size() < expect_q.size()) ? rx_frames.size() : expect_q.size();
		for (int i = 0; i < n; i++) begin
			if (rx_frames[i] !== expect_q[i]) begin
				$display("FAIL t=%0t tx_byte[%0d] expected %h got %h",
					$time, i, expect_q[i], rx_frames[i]);
				errors++;
			end
		end
		rx_frames.delete();
		expect_q.delete();
	endtask

	task automatic check_leds();
		if ({led_r, led_b, led_g} !== model_led) begin
			$display("FAIL t=%0t led_rbg expected %b got %b",
				$time, model_led, {led_r, led_b, led_g});
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == err_mark) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			$display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
			tests_failed++;
		end
		err_mark = errors;
	endtask

	initial begin
		byte_t w;
		int    n;
		int    warm;
		string ops;
		ops = "+-&|=doxn~z";
		rx = 1'b1;
		reset = 1'b0;
		for (int i = 0; i < 16; i++) begin
			model_cells[i] = '0;
		end
		model_sp = '0;
		model_led = '1;
		repeat (3) @(negedge clk);
		reset = 1'b1;

		// Idle line and dark LEDs after reset
		for (int i = 0; i < 20 * CLKS_PER_BIT; i++) begin
			@(negedge clk);
			if (tx !== 1'b1) begin
				$display("FAIL t=%0t tx expected 1 got %b", $time, tx);
				errors++;
			end
			check_leds();
		end
		check_frames();
		end_test("reset idle");

		// Push then emit
		for (int i = 0; i < 10; i++) begin
			send_word(rand_digit());
			send_word(".");
		end
		check_frames();
		end_test("digit echo");

		// Leading pushes past 16 cells exercise the wrap
		for (int p = 0; p < NUM_PROGRAMS; p++) begin
			warm = next_random() % 20;
			n = warm + 1 + next_random() % 12;
			for (int i = 0; i < n; i++) begin
				if (i < warm || next_random() % 3 == 0) begin
					send_word(rand_digit());
				end else begin
					send_word(ops[next_random() % 11]);
				end
			end
			send_word(".");
			check_frames();
		end
		end_test("random programs");

		// io_led, then levels hold over other words
		for (int i = 0; i < 8; i++) begin
			send_word(rand_digit());
			send_word("l");
			check_leds();
			send_word(rand_digit());
			send_word(" ");
			send_word("d");
			check_leds();
		end
		check_frames();
		end_test("led output");

		// Blanks, digits and unknown bytes
		for (int i = 0; i < 30; i++) begin
			case (next_random() % 3)
				0: begin
					n = next_random() % 5;
					w = (n == 0) ? " " : byte_t'(9 + n);
					send_word(w);
				end
				1: send_word(rand_digit());
				default: begin
					do begin
						w = byte_t'(next_random());
					end while (word_is_known(w));
					send_word(w);
				end
			endcase
		end
		send_word(".");
		check_frames();
		end_test("blanks and errors");

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
